// ==== Makefile ====
# Verilator flow for the memory endpoint testbench

VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert
TOP       ?= testbench
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulation binary is the test result
sim: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

// ==== hw/umi_fifo.sv ====
module umi_fifo #(
	parameter type PAYLOAD    = logic [7:0],
	parameter int  FIFO_DEPTH = 4
) (
	input  logic   clk,
	input  logic   rst_n,

	input  PAYLOAD in_data,
	input  logic   in_valid,
	output logic   in_ready,

	output PAYLOAD out_data,
	output logic   out_valid,
	input  logic   out_ready
);

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	PAYLOAD mem [FIFO_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	logic push;
	logic pop;

	// Both readies come from the count alone
	assign in_ready  = (count != CNT_W'(FIFO_DEPTH));
	assign out_valid = (count != '0);
	assign out_data  = mem[rd_ptr];

	assign push = in_valid && in_ready;
	assign pop  = out_valid && out_ready;

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= in_data;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			// Pointers wrap at the last slot, depth need not be a power of two
			if (push) begin
				if (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) begin
					wr_ptr <= '0;
				end else begin
					wr_ptr <= wr_ptr + 1'b1;
				end
			end
			if (pop) begin
				if (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) begin
					rd_ptr <= '0;
				end else begin
					rd_ptr <= rd_ptr + 1'b1;
				end
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// ==== hw/umi_mem_target.sv ====
module umi_mem_target
	import umi_pkg::*;
#(
	parameter int MEM_WORDS = 256
) (
	input  logic               clk,
	input  logic               rst_n,

	input  umi_req_t           req,
	input  logic               req_valid,
	output logic               req_ready,

	output umi_pkt_t           resp_pkt,
	output logic               resp_valid,
	input  logic               resp_ready,

	output logic               trace_valid,
	output logic [TRACE_W-1:0] trace_data
);

	localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

	logic [UMI_DATA_W-1:0] mem [MEM_WORDS];

	// Clear sweep after reset
	logic             clr_busy;
	logic [IDX_W-1:0] clr_idx;

	logic             accept;
	logic             is_write;
	logic             has_resp;
	logic [IDX_W-1:0] idx;
	umi_resp_t        resp_n;

	// Decoder guarantees the index is in range for non-error requests
	assign idx = req.word[IDX_W-1:0];

	assign req_ready = !clr_busy && (!resp_valid || resp_ready);
	assign accept    = req_valid && req_ready;
	assign is_write  = (req.kind == KIND_WRITE) || (req.kind == KIND_POSTED);
	assign has_resp  = (req.kind != KIND_POSTED);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			clr_busy <= 1'b1;
			clr_idx  <= '0;
		end else if (clr_busy) begin
			if (clr_idx == IDX_W'(MEM_WORDS - 1)) begin
				clr_busy <= 1'b0;
			end
			clr_idx <= clr_idx + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (clr_busy) begin
			mem[clr_idx] <= '0;
		end else if (accept && is_write) begin
			mem[idx] <= req.data;
		end
	end

	// Response fields, tag and address always echoed
	always_comb begin
		resp_n      = '0;
		resp_n.tag  = req.tag;
		resp_n.addr = req.addr;
		case (req.kind)
			KIND_READ: begin
				resp_n.opcode = OP_RESP_READ;
				resp_n.data   = mem[idx];
			end
			KIND_WRITE: begin
				resp_n.opcode = OP_RESP_WRITE;
			end
			default: begin
				resp_n.opcode = OP_RESP_ERROR;
			end
		endcase
	end

	// Single response register
	always_ff @(posedge clk) begin
		if (accept && has_resp) begin
			resp_pkt <= umi_pkt_t'(resp_n);
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			resp_valid <= 1'b0;
		end else if (accept && has_resp) begin
			resp_valid <= 1'b1;
		end else if (resp_ready) begin
			resp_valid <= 1'b0;
		end
	end

	// Write trace, one cycle after the write is taken
	always_ff @(posedge clk) begin
		if (accept && is_write) begin
			trace_data <= {req.addr, req.data};
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			trace_valid <= 1'b0;
		end else begin
			trace_valid <= accept && is_write;
		end
	end

endmodule

// ==== hw/umi_pkg.sv ====
package umi_pkg;

	// Packet and field widths
	localparam int UMI_PKT_W  = 256;
	localparam int UMI_OPC_W  = 8;
	localparam int UMI_TAG_W  = 8;
	localparam int UMI_ADDR_W = 32;
	localparam int UMI_DATA_W = 64;

	// Word index of a byte address, 8 bytes per word
	localparam int UMI_WORD_W = UMI_ADDR_W - 3;

	// Field positions inside a packet
	localparam int UMI_OPC_LSB  = 0;
	localparam int UMI_TAG_LSB  = 8;
	localparam int UMI_ADDR_LSB = 16;
	localparam int UMI_DATA_LSB = 48;

	// Unused upper bits of a packet
	localparam int UMI_PAD_W = UMI_PKT_W - UMI_DATA_W - UMI_ADDR_W - UMI_TAG_W - UMI_OPC_W;

	// Write trace, address above data
	localparam int TRACE_W = UMI_ADDR_W + UMI_DATA_W;

	typedef logic [UMI_PKT_W-1:0] umi_pkt_t;

	typedef enum logic [UMI_OPC_W-1:0] {
		OP_READ         = 8'h01,
		OP_RESP_READ    = 8'h02,
		OP_WRITE        = 8'h03,
		OP_RESP_WRITE   = 8'h04,
		OP_WRITE_POSTED = 8'h05,
		OP_RESP_ERROR   = 8'h0f
	} umi_opcode_t;

	// Request class after decode
	typedef enum logic [1:0] {
		KIND_READ,
		KIND_WRITE,
		KIND_POSTED,
		KIND_ERROR
	} umi_kind_t;

	// Decoded request, decoder to target
	typedef struct packed {
		umi_kind_t              kind;
		logic [UMI_TAG_W-1:0]   tag;
		logic [UMI_ADDR_W-1:0]  addr;
		logic [UMI_WORD_W-1:0]  word;
		logic [UMI_DATA_W-1:0]  data;
	} umi_req_t;

	// Response layout, same bit positions as a request packet
	typedef struct packed {
		logic [UMI_PAD_W-1:0]   pad;
		logic [UMI_DATA_W-1:0]  data;
		logic [UMI_ADDR_W-1:0]  addr;
		logic [UMI_TAG_W-1:0]   tag;
		umi_opcode_t            opcode;
	} umi_resp_t;

endpackage

// ==== hw/umi_req_decode.sv ====
module umi_req_decode
	import umi_pkg::*;
#(
	parameter int MEM_WORDS = 256
) (
	input  logic     clk,
	input  logic     rst_n,

	input  umi_pkt_t pkt,
	input  logic     pkt_valid,
	output logic     pkt_ready,

	output umi_req_t req,
	output logic     req_valid,
	input  logic     req_ready,

	output logic     trap
);

	logic [UMI_OPC_W-1:0]  opc;
	logic [UMI_TAG_W-1:0]  tag;
	logic [UMI_ADDR_W-1:0] addr;
	logic [UMI_DATA_W-1:0] data;
	logic [UMI_WORD_W-1:0] word;

	logic     illegal;
	logic     bad_addr;
	logic     load;
	umi_req_t req_n;

	// Field extraction, upper packet bits are ignored
	assign opc  = pkt[UMI_OPC_LSB  +: UMI_OPC_W];
	assign tag  = pkt[UMI_TAG_LSB  +: UMI_TAG_W];
	assign addr = pkt[UMI_ADDR_LSB +: UMI_ADDR_W];
	assign data = pkt[UMI_DATA_LSB +: UMI_DATA_W];
	assign word = addr[UMI_ADDR_W-1:3];

	assign bad_addr = (addr[2:0] != 3'b000) || (word >= UMI_WORD_W'(MEM_WORDS));

	// Output register is empty or drains this cycle
	assign pkt_ready = !req_valid || req_ready;
	assign load      = pkt_valid && pkt_ready;

	always_comb begin
		illegal    = 1'b0;
		req_n.tag  = tag;
		req_n.addr = addr;
		req_n.word = word;
		req_n.data = data;
		case (opc)
			OP_READ:         req_n.kind = KIND_READ;
			OP_WRITE:        req_n.kind = KIND_WRITE;
			OP_WRITE_POSTED: req_n.kind = KIND_POSTED;
			default: begin
				req_n.kind = KIND_ERROR;
				illegal    = 1'b1;
			end
		endcase
		// Bad address turns a legal request into an error, no trap
		if (bad_addr) begin
			req_n.kind = KIND_ERROR;
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			req <= req_n;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			req_valid <= 1'b0;
			trap      <= 1'b0;
		end else begin
			// High only in the first cycle the bad request sits on req
			trap <= load && illegal;
			if (load) begin
				req_valid <= 1'b1;
			end else if (req_ready) begin
				req_valid <= 1'b0;
			end
		end
	end

endmodule

// ==== hw/zverif_top.sv ====
module zverif_top
	import umi_pkg::*;
#(
	parameter int MEM_WORDS  = 256,
	parameter int FIFO_DEPTH = 4
) (
	input  logic               clk,
	input  logic               rst_n,

	// Request port
	input  umi_pkt_t           umi_packet_rx,
	input  logic               umi_valid_rx,
	output logic               umi_ready_rx,

	// Response port
	output umi_pkt_t           umi_packet_tx,
	output logic               umi_valid_tx,
	input  logic               umi_ready_tx,

	output logic               trap,
	output logic               trace_valid,
	output logic [TRACE_W-1:0] trace_data
);

	// Request queue to decoder
	umi_pkt_t pkt;
	logic     pkt_valid;
	logic     pkt_ready;

	// Decoder to target
	umi_req_t req;
	logic     req_valid;
	logic     req_ready;

	// Target to response queue
	umi_pkt_t resp_pkt;
	logic     resp_valid;
	logic     resp_ready;

	umi_fifo #(
		.PAYLOAD    (umi_pkt_t),
		.FIFO_DEPTH (FIFO_DEPTH)
	) rx_fifo_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_data   (umi_packet_rx),
		.in_valid  (umi_valid_rx),
		.in_ready  (umi_ready_rx),
		.out_data  (pkt),
		.out_valid (pkt_valid),
		.out_ready (pkt_ready)
	);

	umi_req_decode #(
		.MEM_WORDS (MEM_WORDS)
	) req_decode_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.pkt       (pkt),
		.pkt_valid (pkt_valid),
		.pkt_ready (pkt_ready),
		.req       (req),
		.req_valid (req_valid),
		.req_ready (req_ready),
		.trap      (trap)
	);

	umi_mem_target #(
		.MEM_WORDS (MEM_WORDS)
	) mem_target_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.req         (req),
		.req_valid   (req_valid),
		.req_ready   (req_ready),
		.resp_pkt    (resp_pkt),
		.resp_valid  (resp_valid),
		.resp_ready  (resp_ready),
		.trace_valid (trace_valid),
		.trace_data  (trace_data)
	);

	umi_fifo #(
		.PAYLOAD    (umi_pkt_t),
		.FIFO_DEPTH (FIFO_DEPTH)
	) tx_fifo_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_data   (resp_pkt),
		.in_valid  (resp_valid),
		.in_ready  (resp_ready),
		.out_data  (umi_packet_tx),
		.out_valid (umi_valid_tx),
		.out_ready (umi_ready_tx)
	);

endmodule

// ==== tests/testbench.sv ====
module testbench
	import umi_pkg::*;
();

	localparam int MEM_WORDS = 256;
	localparam int IDX_W     = $clog2(MEM_WORDS);
	localparam int TIMEOUT   = 200;

	logic               clk = 1'b0;
	logic               rst_n;
	umi_pkt_t           umi_packet_rx;
	logic               umi_valid_rx;
	logic               umi_ready_rx;
	umi_pkt_t           umi_packet_tx;
	logic               umi_valid_tx;
	logic               umi_ready_tx = 1'b1;
	logic               trap;
	logic               trace_valid;
	logic [TRACE_W-1:0] trace_data;

	// Reference model state
	logic [UMI_DATA_W-1:0] ref_mem [MEM_WORDS];
	umi_pkt_t              exp_q [$];
	logic [TRACE_W-1:0]    trace_q [$];
	int                    trap_count = 0;
	integer                seed;
	logic                  tx_random;

	zverif_top #(
		.MEM_WORDS  (MEM_WORDS),
		.FIFO_DEPTH (4)
	) zverif_top_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.umi_packet_rx (umi_packet_rx),
		.umi_valid_rx  (umi_valid_rx),
		.umi_ready_rx  (umi_ready_rx),
		.umi_packet_tx (umi_packet_tx),
		.umi_valid_tx  (umi_valid_tx),
		.umi_ready_tx  (umi_ready_tx),
		.trap          (trap),
		.trace_valid   (trace_valid),
		.trace_data    (trace_data)
	);

	always #20 clk = ~clk;

	task automatic stop_on_failure();
		$display("Some tests failed");
		$fatal(1, "testbench stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [63:0] actual,
			input logic [63:0] expected);
		assert (actual === expected) else begin
			$display("Fail %s: got 0x%0h, expected 0x%0h", name, actual, expected);
			stop_on_failure();
		end
	endtask

	task automatic report_hang(input string what, input int limit);
		$display("Timeout: no progress on %s within %0d cycles", what, limit);
		stop_on_failure();
	endtask

	// Advance to the next falling edge and redraw tx ready
	task automatic tick();
		@(negedge clk);
		if (tx_random) begin
			umi_ready_tx = 1'($random(seed));
		end else begin
			umi_ready_tx = 1'b1;
		end
	endtask

	function automatic logic [31:0] rand_addr();
		int unsigned w;
		w = $unsigned($random(seed)) % MEM_WORDS;
		return 32'(w) << 3;
	endfunction

	function automatic logic [63:0] rand_data();
		return {$random(seed), $random(seed)};
	endfunction

	// Expected response and memory update of one request
	task automatic expect_req(input logic [7:0] opc, input logic [7:0] tag,
			input logic [31:0] addr, input logic [63:0] data);
		int unsigned      word;
		logic [IDX_W-1:0] widx;
		umi_resp_t        resp;
		word = addr >> 3;
		widx = IDX_W'(word);
		resp = '0;
		resp.tag  = tag;
		resp.addr = addr;
		if (addr[2:0] != 3'b000 || word >= MEM_WORDS ||
				!(opc == OP_READ || opc == OP_WRITE || opc == OP_WRITE_POSTED)) begin
			resp.opcode = OP_RESP_ERROR;
			exp_q.push_back(umi_pkt_t'(resp));
		end else if (opc == OP_READ) begin
			resp.opcode = OP_RESP_READ;
			resp.data   = ref_mem[widx];
			exp_q.push_back(umi_pkt_t'(resp));
		end else begin
			ref_mem[widx] = data;
			trace_q.push_back({addr, data});
			if (opc == OP_WRITE) begin
				resp.opcode = OP_RESP_WRITE;
				exp_q.push_back(umi_pkt_t'(resp));
			end
		end
	endtask

	task automatic send_req(input logic [7:0] opc, input logic [7:0] tag,
			input logic [31:0] addr, input logic [63:0] data);
		int waited;
		expect_req(opc, tag, addr, data);
		umi_packet_rx = {{UMI_PAD_W{1'b0}}, data, addr, tag, opc};
		umi_valid_rx  = 1'b1;
		waited = 0;
		// Ready depends on state only, so the falling edge value is the one taken
		while (!umi_ready_rx) begin
			if (waited == TIMEOUT) begin
				report_hang("umi_ready_rx", TIMEOUT);
			end
			tick();
			waited++;
		end
		tick();
		umi_valid_rx = 1'b0;
	endtask

	// The target sweeps its memory to zero before it takes a request
	task automatic wait_mem_clear();
		int waited;
		waited = 0;
		while (!zverif_top_i.req_ready) begin
			if (waited == MEM_WORDS + TIMEOUT) begin
				report_hang("memory clear after reset", MEM_WORDS + TIMEOUT);
			end
			tick();
			waited++;
		end
	endtask

	task automatic wait_idle();
		int waited;
		waited = 0;
		while (exp_q.size() != 0 || trace_q.size() != 0) begin
			if (waited == TIMEOUT) begin
				report_hang("outstanding responses or write traces", TIMEOUT);
			end
			tick();
			waited++;
		end
	endtask

	// Response checker
	always @(posedge clk) begin
		umi_resp_t got;
		umi_resp_t exp;
		if (rst_n && umi_valid_tx && umi_ready_tx) begin
			assert (exp_q.size() != 0) else begin
				$display("Response arrived with no request outstanding");
				stop_on_failure();
			end
			got = umi_resp_t'(umi_packet_tx);
			exp = umi_resp_t'(exp_q.pop_front());
			check_value("umi_packet_tx.opcode", 64'(got.opcode), 64'(exp.opcode));
			check_value("umi_packet_tx.tag", 64'(got.tag), 64'(exp.tag));
			check_value("umi_packet_tx.addr", 64'(got.addr), 64'(exp.addr));
			check_value("umi_packet_tx.data", got.data, exp.data);
			check_value("umi_packet_tx.pad nonzero", 64'(got.pad != '0), 64'd0);
		end
	end

	// Write trace checker and trap counter
	always @(posedge clk) begin
		logic [TRACE_W-1:0] exp_t;
		if (rst_n && trace_valid) begin
			assert (trace_q.size() != 0) else begin
				$display("Write trace with no write outstanding");
				stop_on_failure();
			end
			exp_t = trace_q.pop_front();
			check_value("trace_data.addr", 64'(trace_data[TRACE_W-1:UMI_DATA_W]),
				64'(exp_t[TRACE_W-1:UMI_DATA_W]));
			check_value("trace_data.data", trace_data[UMI_DATA_W-1:0],
				exp_t[UMI_DATA_W-1:0]);
		end
		if (rst_n && trap) begin
			trap_count++;
		end
	end

	initial begin
		logic [31:0] addrs [8];
		logic [31:0] addr;
		logic [63:0] data;
		logic [7:0]  opc;
		int          trap_before;
		int          pick;
		seed          = 32'h43f04cf9;
		rst_n         = 1'b0;
		umi_packet_rx = '0;
		umi_valid_rx  = 1'b0;
		tx_random     = 1'b0;
		for (int i = 0; i < MEM_WORDS; i++) begin
			ref_mem[i] = '0;
		end
		repeat (4) @(posedge clk);
		tick();
		rst_n = 1'b1;
		check_value("umi_valid_tx", 64'(umi_valid_tx), 64'd0);
		check_value("trap", 64'(trap), 64'd0);
		check_value("trace_valid", 64'(trace_valid), 64'd0);

		wait_mem_clear();

		// First isolated request reads an unwritten word
		send_req(OP_READ, 8'h00, rand_addr(), 64'd0);
		wait_idle();

		for (int i = 0; i < 8; i++) begin
			addrs[i] = rand_addr();
			send_req(OP_WRITE, 8'(i + 8'h10), addrs[i], rand_data());
			wait_idle();
		end
		for (int i = 0; i < 8; i++) begin
			send_req(OP_READ, 8'(i + 8'h20), addrs[i], rand_data());
			wait_idle();
		end

		// Posted write followed by a read back
		addr = rand_addr();
		send_req(OP_WRITE_POSTED, 8'h30, addr, rand_data());
		wait_idle();
		send_req(OP_READ, 8'h31, addr, 64'd0);
		wait_idle();

		// Illegal opcode on a written word must leave it alone
		trap_before = trap_count;
		send_req(8'h77, 8'h40, addrs[0], rand_data());
		wait_idle();
		check_value("trap pulse count", 64'(trap_count), 64'(trap_before + 1));
		send_req(OP_READ, 8'h41, addrs[0], 64'd0);
		wait_idle();

		// Misaligned and out of range addresses raise no trap
		trap_before = trap_count;
		send_req(OP_WRITE, 8'h50, addrs[1] | 32'h4, rand_data());
		wait_idle();
		send_req(OP_READ, 8'h51, 32'(MEM_WORDS * 8) + addrs[2], 64'd0);
		wait_idle();
		check_value("trap pulse count", 64'(trap_count), 64'(trap_before));
		send_req(OP_READ, 8'h52, addrs[1], 64'd0);
		wait_idle();

		// Back-to-back burst against a randomly stalling tx port
		tx_random = 1'b1;
		for (int i = 0; i < 60; i++) begin
			pick = $unsigned($random(seed)) % 4;
			addr = rand_addr();
			data = rand_data();
			case (pick)
				0: opc = OP_READ;
				1: opc = OP_WRITE;
				2: opc = OP_WRITE_POSTED;
				default: begin
					opc  = OP_WRITE;
					addr = (i % 2 == 0) ? (addr | 32'h2) : (addr + 32'(MEM_WORDS * 8));
				end
			endcase
			send_req(opc, 8'(i), addr, data);
		end
		tx_random = 1'b0;
		wait_idle();

		$display("All tests passed");
		$finish;
	end

endmodule

// ==== tests/testbench_properties.sv ====
module zverif_properties
	import umi_pkg::*;
(
	input logic     clk,
	input logic     rst_n,
	input umi_pkt_t umi_packet_rx,
	input logic     umi_valid_rx,
	input logic     umi_ready_rx,
	input umi_pkt_t umi_packet_tx,
	input logic     umi_valid_tx,
	input logic     umi_ready_tx,
	input logic     trap,
	input logic     trace_valid,
	input logic     pkt_valid,
	input logic     req_valid,
	input logic     req_ready,
	input logic     resp_valid
);

	logic rx_xfer;
	logic pipe_idle;

	assign rx_xfer = umi_valid_rx && umi_ready_rx;
	// Every stage empty and the memory clear finished
	assign pipe_idle = !pkt_valid && !req_valid && !resp_valid && !umi_valid_tx && req_ready;

	rx_hold: assert property (@(posedge clk) disable iff (!rst_n)
		umi_valid_rx && !umi_ready_rx |=> umi_valid_rx && $stable(umi_packet_rx))
		else $error("rx request dropped or changed while stalled");

	tx_hold: assert property (@(posedge clk) disable iff (!rst_n)
		umi_valid_tx && !umi_ready_tx |=> umi_valid_tx && $stable(umi_packet_tx))
		else $error("tx response dropped or changed while stalled");

	// Covers the reset cycles and the first cycle after release
	reset_quiet: assert property (@(posedge clk)
		!rst_n |=> !umi_valid_tx && !trap && !trace_valid)
		else $error("output active during or right after reset");

	trap_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		trap |=> !trap)
		else $error("trap held longer than one cycle");

	// Posted writes send nothing back
	isolated_latency: assert property (@(posedge clk) disable iff (!rst_n)
		rx_xfer && pipe_idle && umi_ready_tx && (umi_packet_rx[7:0] != OP_WRITE_POSTED)
		|-> ##1 !umi_valid_tx ##1 !umi_valid_tx ##1 !umi_valid_tx ##1 umi_valid_tx)
		else $error("response of an isolated request not valid after 4 cycles");

endmodule

bind zverif_top zverif_properties zverif_properties_i (
	.clk           (clk),
	.rst_n         (rst_n),
	.umi_packet_rx (umi_packet_rx),
	.umi_valid_rx  (umi_valid_rx),
	.umi_ready_rx  (umi_ready_rx),
	.umi_packet_tx (umi_packet_tx),
	.umi_valid_tx  (umi_valid_tx),
	.umi_ready_tx  (umi_ready_tx),
	.trap          (trap),
	.trace_valid   (trace_valid),
	.pkt_valid     (pkt_valid),
	.req_valid     (req_valid),
	.req_ready     (req_ready),
	.resp_valid    (resp_valid)
);

// ==== vlog.f ====
hw/umi_pkg.sv
hw/umi_fifo.sv
hw/umi_req_decode.sv
hw/umi_mem_target.sv
hw/zverif_top.sv
tests/testbench_properties.sv
tests/testbench.sv
